// File: controllerPkg.sv
`default_nettype none

package controllerPkg;

    typedef logic [15:0] opcode_t; // Instruction word
    typedef logic [3:0] flags_t; // Flag register image
    typedef logic [3:0] aluFunc_t; // ALU operation code
    typedef logic [2:0] aluSrc_t; // ALU input select
    typedef logic [1:0] regSel_t; // Register number
    typedef logic [2:0] dest_t; // Destination code

    typedef enum logic [3:0] {
        START = 4'd0,
        FETCH = 4'd1,
        RIMMED = 4'd2, // Read immediate operand
        RADDRESS = 4'd3, // Read operand at address in A
        ATYPE = 4'd4,
        ITYPE = 4'd5,
        JTYPE = 4'd6,
        JFLAG = 4'd7, // Taken flag jump
        HALT = 4'd15
    } ctrlState_t;

    typedef enum logic [2:0] {
        clsA,
        clsI,
        clsJ,
        clsJumpFlag,
        clsSkip, // Flag condition false
        clsFlagOp, // Set or clear a flag
        clsIllegal
    } instrClass_t;

    typedef enum logic [1:0] {
        srcReg,
        srcImm,
        srcAddr
    } srcMode_t;

    // Destination codes
    localparam dest_t destZero = 3'd0;
    localparam dest_t destA = 3'd1;
    localparam dest_t destB = 3'd2;
    localparam dest_t destC = 3'd3;
    localparam dest_t destAdr = 3'd4;

    // Codes 0-3 of ALU input A pick a register
    localparam aluSrc_t aluAFromPc = 3'd4;
    localparam aluSrc_t aluAFromMem = 3'd5;

    // Codes 0-3 of ALU input B pick a register
    localparam aluSrc_t aluBFromOne = 3'd4;
    localparam aluSrc_t aluBFromZero = 3'd5;
    localparam aluSrc_t aluBFromOp = 3'd6;
    localparam aluSrc_t aluBFromAddr = 3'd7;

    // Memory address source
    localparam logic memFromPc = 1'b0;
    localparam logic memFromA = 1'b1;

    localparam aluFunc_t aluAdd = 4'd0;
    localparam aluFunc_t aluMul = 4'd4;
    localparam aluFunc_t aluJump = 4'd6; // PC plus signed offset

endpackage

`default_nettype wire

// File: decodeIf.sv
`timescale 1ns/10ps
`default_nettype none

interface decodeIf import controllerPkg::*; ();

    instrClass_t instrClass;
    srcMode_t srcMode;
    regSel_t srcReg; // Register for ALU input A
    regSel_t srcRegB; // A-type register for ALU input B
    dest_t dest;
    aluFunc_t aluFunc;
    flags_t newFlags; // Flag image for set/clear

    modport producer (
        output instrClass, srcMode, srcReg, srcRegB, dest, aluFunc, newFlags
    );

    modport consumer (
        input instrClass, srcMode, srcReg, srcRegB, dest, aluFunc, newFlags
    );

endinterface

`default_nettype wire

// File: instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import controllerPkg::*; (
    input opcode_t opcode,
    input flags_t flags,
    decodeIf.producer dec
);

    logic [2:0] srcField;
    logic isIType;
    logic srcLegal;
    logic destLegal;
    dest_t destCode;

    assign srcField = opcode[11:9];
    assign isIType = (opcode[15:14] == 2'b01);

    always_comb begin
        srcLegal = 1'b1;
        dec.srcMode = srcReg;
        if (srcField[2] == 1'b0) begin
            dec.srcMode = srcReg; // Register 0-3
        end else if (srcField == 3'b100) begin
            dec.srcMode = srcImm;
        end else if (srcField == 3'b110) begin
            dec.srcMode = srcAddr;
        end else begin
            srcLegal = 1'b0; // Modes 5 and 7 are illegal
        end
    end

    assign dec.srcReg = srcField[1:0];
    assign dec.srcRegB = opcode[4:3];

    // I-type writes back where it reads from
    assign destCode = isIType ? srcField : opcode[2:0];
    assign dec.dest = destCode;

    always_comb begin
        destLegal = (destCode <= destAdr);
        if (isIType && destCode == destZero) begin
            destLegal = 1'b0; // No register 0 operand in I-type
        end
    end

    always_comb begin
        if (isIType) begin
            dec.aluFunc = {opcode[8], opcode[8], opcode[13:12]};
        end else begin
            dec.aluFunc = opcode[8:5];
        end
    end

    always_comb begin
        dec.instrClass = clsIllegal;
        if (opcode[15:12] == 4'b0000) begin
            if (srcLegal && destLegal) dec.instrClass = clsA;
        end else if (isIType) begin
            if (srcLegal && destLegal) dec.instrClass = clsI;
        end else if (opcode[15]) begin
            dec.instrClass = clsJ;
        end else if (opcode[15:12] == 4'b0010) begin
            if (opcode[11]) begin
                dec.instrClass = clsFlagOp;
            end else if (flags[opcode[9:8]] == opcode[10]) begin
                dec.instrClass = clsJumpFlag; // Condition holds
            end else begin
                dec.instrClass = clsSkip;
            end
        end
    end

    always_comb begin
        dec.newFlags = flags;
        dec.newFlags[opcode[9:8]] = opcode[10]; // Set or clear selected bit
    end

endmodule

`default_nettype wire

// File: controlSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module controlSequencer import controllerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    decodeIf.consumer dec,
    output ctrlState_t state
);

    ctrlState_t nextState;
    ctrlState_t mainState; // Execute state of the held instruction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (dec.instrClass)
            clsA: mainState = ATYPE;
            clsI: mainState = ITYPE;
            default: mainState = HALT;
        endcase
    end

    always_comb begin
        nextState = HALT;
        case (state)
            START: nextState = FETCH;
            FETCH: begin
                case (dec.instrClass)
                    clsA, clsI: begin
                        case (dec.srcMode)
                            srcImm: nextState = RIMMED;
                            srcAddr: nextState = RADDRESS;
                            default: nextState = mainState; // Register source
                        endcase
                    end
                    clsJ: nextState = JTYPE;
                    clsJumpFlag: nextState = JFLAG;
                    clsSkip, clsFlagOp: nextState = FETCH; // Done in one cycle
                    default: nextState = HALT;
                endcase
            end
            RIMMED, RADDRESS: nextState = mainState;
            ATYPE, ITYPE, JTYPE, JFLAG: nextState = FETCH;
            default: nextState = HALT; // HALT stays until reset
        endcase
    end

endmodule

`default_nettype wire

// File: controlEncoder.sv
`timescale 1ns/10ps
`default_nettype none

module controlEncoder import controllerPkg::*; (
    input ctrlState_t state,
    decodeIf.consumer dec,
    output logic memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output aluFunc_t aluFunc,
    output aluSrc_t aluA,
    output aluSrc_t aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic enF,
    output logic flagFromInstr,
    output logic isMul,
    output flags_t inF
);

    always_comb begin
        memAddr = memFromPc;
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem1 = 1'b0;
        aluFunc = aluAdd;
        aluA = 3'd0;
        aluB = 3'd0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        we = 1'b0;
        re = 1'b0;
        enF = 1'b0;
        flagFromInstr = 1'b0;
        isMul = 1'b0;
        inF = 4'd0;

        case (state)
            FETCH: begin
                memAddr = memFromPc; // Read instruction at PC
                re = 1'b1;
                saveOpcode = 1'b1;
                aluFunc = aluAdd; // PC + 1
                aluA = aluAFromPc;
                aluB = aluBFromOne;
                enPC = 1'b1;
                if (dec.instrClass == clsFlagOp) begin
                    enF = 1'b1;
                    flagFromInstr = 1'b1;
                    inF = dec.newFlags;
                end
            end

            RIMMED: begin
                memAddr = memFromPc; // Operand follows the instruction
                re = 1'b1;
                saveMem1 = 1'b1;
                aluFunc = aluAdd;
                aluA = aluAFromPc;
                aluB = aluBFromOne;
                enPC = 1'b1;
            end

            RADDRESS: begin
                memAddr = memFromA;
                re = 1'b1;
                saveMem1 = 1'b1;
            end

            ATYPE, ITYPE: begin
                if (dec.srcMode == srcReg) begin
                    aluA = {1'b0, dec.srcReg};
                end else begin
                    aluA = aluAFromMem; // Operand latched in mem1
                end
                if (state == ATYPE) begin
                    aluB = {1'b0, dec.srcRegB};
                end else begin
                    aluB = aluBFromOp; // Immediate field of opcode
                end
                aluFunc = dec.aluFunc;
                enF = 1'b1;
                if (dec.aluFunc == aluMul) begin
                    enA = 1'b1; // High half of product goes to A
                    isMul = 1'b1;
                end
                case (dec.dest)
                    destZero: ; // Flags only
                    destA: enA = 1'b1;
                    destB: enB = 1'b1;
                    destC: enC = 1'b1;
                    destAdr: begin
                        we = 1'b1;
                        memAddr = memFromA;
                    end
                    default: ;
                endcase
            end

            JTYPE: begin
                aluA = aluAFromPc;
                aluB = aluBFromAddr; // Offset from instruction
                aluFunc = aluJump;
                enPC = 1'b1;
            end

            JFLAG: begin
                aluA = aluAFromPc;
                aluB = aluBFromOp;
                aluFunc = aluAdd;
                enPC = 1'b1;
            end

            default: ; // START and HALT drive nothing
        endcase
    end

endmodule

`default_nettype wire

// File: cpuController.sv
`timescale 1ns/10ps
`default_nettype none

module cpuController import controllerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall, // Hold current state
    input opcode_t opcode,
    input flags_t flags,
    output logic memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output aluFunc_t aluFunc,
    output aluSrc_t aluA,
    output aluSrc_t aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic enF,
    output logic flagFromInstr,
    output logic isMul,
    output flags_t inF,
    output logic [3:0] state // For debug
);

    decodeIf decBus ();
    ctrlState_t curState;

    assign state = curState;

    instrDecoder decoder_i (
        .opcode (opcode),
        .flags (flags),
        .dec (decBus.producer)
    );

    controlSequencer sequencer_i (
        .clk (clk),
        .rst (rst),
        .stall (stall),
        .dec (decBus.consumer),
        .state (curState)
    );

    controlEncoder encoder_i (
        .state (curState),
        .dec (decBus.consumer),
        .memAddr (memAddr),
        .enPC (enPC),
        .saveOpcode (saveOpcode),
        .saveMem1 (saveMem1),
        .aluFunc (aluFunc),
        .aluA (aluA),
        .aluB (aluB),
        .enA (enA),
        .enB (enB),
        .enC (enC),
        .we (we),
        .re (re),
        .enF (enF),
        .flagFromInstr (flagFromInstr),
        .isMul (isMul),
        .inF (inF)
    );

endmodule

`default_nettype wire

// File: tb_cpuController.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpuController;

    // Each line of controllerInput.txt holds opcode, flags and stall in hex
    // followed by the expected state memAddr enPC saveOpcode saveMem1 aluFunc
    // aluA aluB enA enB enC we re enF flagFromInstr inF isMul
    localparam int fieldsPerLine = 20;
    localparam int maxLines = 64;

    logic clk;
    logic rst;
    logic stall;
    logic [15:0] opcode;
    logic [3:0] flags;
    logic memAddr;
    logic enPC;
    logic saveOpcode;
    logic saveMem1;
    logic [3:0] aluFunc;
    logic [2:0] aluA;
    logic [2:0] aluB;
    logic enA;
    logic enB;
    logic enC;
    logic we;
    logic re;
    logic enF;
    logic flagFromInstr;
    logic isMul;
    logic [3:0] inF;
    logic [3:0] state;

    logic [16:0] vec [0:fieldsPerLine*maxLines-1];
    logic [16:0] f [0:fieldsPerLine-1]; // Fields of the current line
    int numLines;
    int limit;
    int cycles;
    int errors;

    cpuController dut_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not end within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic reportMismatch(input string field, input logic [15:0] got,
                                  input logic [15:0] expected, input int line);
        $display("FAILED at %0t ns: line %0d, %s is %h, expected %h",
                 $time, line, field, got, expected);
        errors++;
    endtask

    task automatic loadVectors();
        int fd;
        int n;
        fd = $fopen("controllerInput.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file controllerInput.txt could not be opened");
            errors++;
        end else begin
            $fclose(fd);
            for (n = 0; n < fieldsPerLine * maxLines; n++) begin
                vec[n] = {1'b1, 16'(n)}; // Bit 16 set marks a slot the file left empty
            end
            $readmemh("controllerInput.txt", vec);
            while (numLines < maxLines && !vec[numLines * fieldsPerLine][16]) begin
                numLines++;
            end
            if (numLines > 0 && vec[numLines * fieldsPerLine - 1][16]) begin
                $display("Stimulus file ends in the middle of line %0d", numLines - 1);
                errors++;
                numLines--; // Drop the partial line
            end
            if (numLines == 0) begin
                $display("Stimulus file holds no complete line");
                errors++;
            end
        end
    endtask

    task automatic checkOutputs(input int line);
        if (state !== f[3][3:0]) reportMismatch("state", 16'(state), f[3][15:0], line);
        if (memAddr !== f[4][0]) reportMismatch("memAddr", 16'(memAddr), f[4][15:0], line);
        if (enPC !== f[5][0]) reportMismatch("enPC", 16'(enPC), f[5][15:0], line);
        if (saveOpcode !== f[6][0]) reportMismatch("saveOpcode", 16'(saveOpcode), f[6][15:0], line);
        if (saveMem1 !== f[7][0]) reportMismatch("saveMem1", 16'(saveMem1), f[7][15:0], line);
        if (aluFunc !== f[8][3:0]) reportMismatch("aluFunc", 16'(aluFunc), f[8][15:0], line);
        if (aluA !== f[9][2:0]) reportMismatch("aluA", 16'(aluA), f[9][15:0], line);
        if (aluB !== f[10][2:0]) reportMismatch("aluB", 16'(aluB), f[10][15:0], line);
        if (enA !== f[11][0]) reportMismatch("enA", 16'(enA), f[11][15:0], line);
        if (enB !== f[12][0]) reportMismatch("enB", 16'(enB), f[12][15:0], line);
        if (enC !== f[13][0]) reportMismatch("enC", 16'(enC), f[13][15:0], line);
        if (we !== f[14][0]) reportMismatch("we", 16'(we), f[14][15:0], line);
        if (re !== f[15][0]) reportMismatch("re", 16'(re), f[15][15:0], line);
        if (enF !== f[16][0]) reportMismatch("enF", 16'(enF), f[16][15:0], line);
        if (flagFromInstr !== f[17][0]) begin
            reportMismatch("flagFromInstr", 16'(flagFromInstr), f[17][15:0], line);
        end
        if (inF !== f[18][3:0]) reportMismatch("inF", 16'(inF), f[18][15:0], line);
        if (isMul !== f[19][0]) reportMismatch("isMul", 16'(isMul), f[19][15:0], line);
    endtask

    initial begin
        int i;
        int k;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        opcode = 16'h0000;
        flags = 4'h0;
        errors = 0;
        cycles = 0;
        numLines = 0;
        limit = 28;
        loadVectors();
        limit = numLines + 8 + 20; // File lines, reset and some slack

        // Reset covers these seven cycles and line 0 of the file
        repeat (7) begin
            @(posedge clk);
            #10;
            if (state !== 4'd0 || {memAddr, enPC, saveOpcode, saveMem1, aluFunc, aluA, aluB,
                    enA, enB, enC, we, re, enF, flagFromInstr, isMul, inF} !== '0) begin
                $display("FAILED at %0t ns: outputs not idle during reset", $time);
                errors++;
            end
        end

        for (i = 0; i < numLines; i++) begin
            @(posedge clk);
            rst <= 1'b0; // Still sampled high on the edge of line 0
            for (k = 0; k < fieldsPerLine; k++) begin
                f[k] = vec[i * fieldsPerLine + k];
            end
            opcode <= f[0][15:0];
            flags <= f[1][3:0];
            stall <= f[2][0];
            #10;
            checkOutputs(i);
        end

        $display("Lines checked: %0d, errors: %0d", numLines, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: controllerInput.txt
// opcode flags stall, then expected state memAddr enPC saveOpcode saveMem1 aluFunc
// aluA aluB enA enB enC we re enF flagFromInstr inF isMul (all hex)
0000 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  // START as reset is released
0272 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // A-type reg 1, dest B
0272 0 0  4 0 0 0 0 3 1 2 0 1 0 0 0 1 0 0 0
049B 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // MUL, dest C
049B 0 0  4 0 0 0 0 4 2 3 1 0 1 0 0 1 0 0 1
5825 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // I-type immediate to memory
5825 0 0  2 0 1 0 1 0 4 4 0 0 0 0 1 0 0 0 0
5825 0 0  5 1 0 0 0 1 5 6 0 0 0 1 0 1 0 0 0
0C4C 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // A-type operand at A, to memory
0C4C 0 0  3 1 0 0 1 0 0 0 0 0 0 0 1 0 0 0 0
0C4C 0 0  4 1 0 0 0 2 5 1 0 0 0 1 0 1 0 0 0
8012 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // J-type
8012 0 0  6 0 1 0 0 6 4 7 0 0 0 0 0 0 0 0 0
2504 2 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // Flag jump taken
2504 2 0  7 0 1 0 0 0 4 6 0 0 0 0 0 0 0 0 0
2504 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // Flag jump not taken
2E00 9 0  1 0 1 1 0 0 4 4 0 0 0 0 1 1 1 D 0  // Set flag 2
2800 F 0  1 0 1 1 0 0 4 4 0 0 0 0 1 1 1 E 0  // Clear flag 0
0272 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0
0272 0 1  4 0 0 0 0 3 1 2 0 1 0 0 0 1 0 0 0  // Stall holds ATYPE
0272 0 1  4 0 0 0 0 3 1 2 0 1 0 0 0 1 0 0 0
0272 0 0  4 0 0 0 0 3 1 2 0 1 0 0 0 1 0 0 0
3000 0 0  1 0 1 1 0 0 4 4 0 0 0 0 1 0 0 0 0  // Old SP-type opcode
3000 0 0  F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0272 0 0  F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8012 0 1  F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: files.f
controllerPkg.sv
decodeIf.sv
instrDecoder.sv
controlSequencer.sv
controlEncoder.sv
cpuController.sv
tb_cpuController.sv

// File: runSim.sh
#!/bin/bash
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_cpuController -o simCpuController
./obj_dir/simCpuController | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "Run passed"
    exit 0
else
    echo "Run failed"
    exit 1
fi
